// File: logic/isaPkg.sv
package isaPkg;

    localparam int regAddrW = 5;     // Bits per register index
    localparam int numRegs = 32;     // General registers incl. r0

    localparam int opcodeLsb = 26;   // instr[31:26]
    localparam int rsLsb = 21;       // instr[25:21]
    localparam int rtLsb = 16;       // instr[20:16]
    localparam int rdLsb = 11;       // instr[15:11]
    localparam int immW = 16;        // instr[15:0], I-type immediate

    // Primary opcodes, MIPS encoding
    typedef enum logic [5:0] {
        rType = 6'b000000,           // ALU ops, funct picks the operation
        j     = 6'b000010,
        beq   = 6'b000100,
        bne   = 6'b000101,
        addi  = 6'b001000,
        lw    = 6'b100011,
        sw    = 6'b101011
    } opcodeT;

    // R-type funct field, instr[5:0]
    typedef enum logic [5:0] {
        fAdd = 6'b100000,
        fSub = 6'b100010,
        fAnd = 6'b100100,
        fOr  = 6'b100101,
        fSlt = 6'b101010
    } functT;

endpackage

// File: logic/coreCfgPkg.sv
package coreCfgPkg;

    localparam int dataW = 32;       // One machine word
    localparam int sliceW = 4;       // Bits per lookahead slice
    localparam int numSlices = 8;    // dataW / sliceW

    localparam int romDepth = 256;   // Instruction words
    localparam string programFile = "program.hex";

    // ALU operation, bit 2 inverts operand b and forces carry-in
    typedef enum logic [2:0] {
        opAnd = 3'b000,
        opOr  = 3'b001,
        opAdd = 3'b010,
        opSub = 3'b110,
        opSlt = 3'b111
    } aluOpT;

endpackage

// File: logic/instructionRom.sv
`timescale 1ns/1ps

module instructionRom (
    input  logic [coreCfgPkg::dataW-1:0] pc,
    output logic [coreCfgPkg::dataW-1:0] instr
);
    import coreCfgPkg::*;

    logic [dataW-1:0] romMem [romDepth];
    logic [dataW-3:0] wordAddr;                     // PC in words

    initial begin
        for (int i = 0; i < romDepth; i++) begin
            romMem[i] = '0;                         // Unfilled words read as no-op
        end
        $readmemh(programFile, romMem);
    end

    assign wordAddr = pc[dataW-1:2];                // Low two bits always zero

    always_comb begin
        if (wordAddr < romDepth) begin
            instr = romMem[wordAddr[$clog2(romDepth)-1:0]];
        end else begin
            instr = '0;                             // Past the end, sll r0 = nop
        end
    end

endmodule

// File: logic/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input  isaPkg::opcodeT    opcode,
    input  isaPkg::functT     funct,
    output logic              aluSrc,
    output logic              regDst,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              regWrite,
    output logic              beqEn,
    output logic              bneEn,
    output logic              jumpEn,
    output coreCfgPkg::aluOpT aluOp
);
    import isaPkg::*;
    import coreCfgPkg::*;

    always_comb begin
        aluSrc = 1'b0;                              // Everything idle unless decoded
        regDst = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        beqEn = 1'b0;
        bneEn = 1'b0;
        jumpEn = 1'b0;
        aluOp = opAdd;

        case (opcode)
            rType: begin
                regDst = 1'b1;                      // Write rd
                regWrite = 1'b1;
                case (funct)
                    fAdd: aluOp = opAdd;
                    fSub: aluOp = opSub;
                    fAnd: aluOp = opAnd;
                    fOr:  aluOp = opOr;
                    fSlt: aluOp = opSlt;
                    default: regWrite = 1'b0;       // Unknown funct, no effect
                endcase
            end
            addi: begin
                aluSrc = 1'b1;                      // rs + imm into rt
                regWrite = 1'b1;
            end
            lw: begin
                aluSrc = 1'b1;                      // Address = rs + imm
                memRead = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            sw: begin
                aluSrc = 1'b1;
                memWrite = 1'b1;                    // rt goes out as store data
            end
            beq: begin
                beqEn = 1'b1;
                aluOp = opSub;                      // Zero flag means equal
            end
            bne: begin
                bneEn = 1'b1;
                aluOp = opSub;
            end
            j: jumpEn = 1'b1;
            default: ;                              // Unknown opcode acts as nop
        endcase
    end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                          Clk,
    input  logic                          rst,
    input  logic [isaPkg::regAddrW-1:0]   rdAddrA,
    input  logic [isaPkg::regAddrW-1:0]   rdAddrB,
    input  logic [isaPkg::regAddrW-1:0]   wrAddr,
    input  logic [coreCfgPkg::dataW-1:0]  wrData,
    input  logic                          wrEn,
    output logic [coreCfgPkg::dataW-1:0]  rdDataA,
    output logic [coreCfgPkg::dataW-1:0]  rdDataB
);
    import isaPkg::*;
    import coreCfgPkg::*;

    logic [dataW-1:0] regs [numRegs];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;                      // All registers start at zero
            end
        end else if (wrEn && wrAddr != '0) begin    // r0 stays zero
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];                 // Async read, rs
    assign rdDataB = regs[rdAddrB];                 // Async read, rt

endmodule

// File: logic/aluSlice.sv
`timescale 1ns/1ps

module aluSlice (
    input  logic [coreCfgPkg::sliceW-1:0] a,
    input  logic [coreCfgPkg::sliceW-1:0] b,
    input  logic                          invertB,
    input  logic                          cin,
    input  coreCfgPkg::aluOpT             aluOp,
    input  logic                          lessIn,
    output logic [coreCfgPkg::sliceW-1:0] result,
    output logic                          groupG,
    output logic                          groupP,
    output logic                          signSum
);
    import coreCfgPkg::*;

    logic [sliceW-1:0] bEff;                        // b or ~b
    logic [sliceW-1:0] g;                           // Bit generate
    logic [sliceW-1:0] p;                           // Bit propagate
    logic [sliceW-1:0] carry;                       // Carry into each bit
    logic [sliceW-1:0] sum;

    assign bEff = invertB ? ~b : b;
    assign g = a & bEff;
    assign p = a | bEff;

    // Flat lookahead, each carry straight from g, p and cin
    assign carry[0] = cin;
    assign carry[1] = g[0] | (p[0] & cin);
    assign carry[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign carry[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                    | (p[2] & p[1] & p[0] & cin);

    assign groupG = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                  | (p[3] & p[2] & p[1] & g[0]);   // Slice generates a carry
    assign groupP = &p;                             // Slice passes cin through

    assign sum = a ^ bEff ^ carry;
    assign signSum = sum[sliceW-1];                 // Raw sign, only top slice matters

    always_comb begin
        case (aluOp)
            opAnd: result = g;
            opOr: result = p;
            opAdd, opSub: result = sum;
            opSlt: result = {{(sliceW-1){1'b0}}, lessIn}; // Only slice 0 sees real less
            default: result = '0;
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [coreCfgPkg::dataW-1:0] a,
    input  logic [coreCfgPkg::dataW-1:0] b,
    input  coreCfgPkg::aluOpT            aluOp,
    output logic [coreCfgPkg::dataW-1:0] result,
    output logic                         zero
);
    import coreCfgPkg::*;

    logic                 invertB;
    logic [numSlices-1:0] groupG;
    logic [numSlices-1:0] groupP;
    logic [numSlices-1:0] signSum;
    logic [numSlices-1:0] sliceCin;
    logic [numSlices-1:0] lessVec;                  // less into slice 0 only
    logic                 bTop;                     // Sign of effective b
    logic                 overflow;
    logic                 less;

    assign invertB = aluOp[2];                      // sub and slt

    // Second level lookahead across slices
    always_comb begin
        logic term;
        for (int k = 0; k < numSlices; k++) begin
            sliceCin[k] = invertB;                  // +1 completes two's complement
            for (int i = 0; i < k; i++) begin
                sliceCin[k] = sliceCin[k] & groupP[i];
            end
            for (int src = 0; src < k; src++) begin
                term = groupG[src];
                for (int i = src + 1; i < k; i++) begin
                    term = term & groupP[i];
                end
                sliceCin[k] = sliceCin[k] | term;
            end
        end
    end

    for (genvar s = 0; s < numSlices; s++) begin : genSlice
        aluSlice sliceInst (
            .a       (a[s*sliceW +: sliceW]),
            .b       (b[s*sliceW +: sliceW]),
            .invertB (invertB),
            .cin     (sliceCin[s]),
            .aluOp   (aluOp),
            .lessIn  (lessVec[s]),
            .result  (result[s*sliceW +: sliceW]),
            .groupG  (groupG[s]),
            .groupP  (groupP[s]),
            .signSum (signSum[s])
        );
    end

    assign bTop = invertB ? ~b[dataW-1] : b[dataW-1];
    // Same input signs but sum sign flipped
    assign overflow = (a[dataW-1] == bTop) & (signSum[numSlices-1] != a[dataW-1]);
    assign less = signSum[numSlices-1] ^ overflow;  // True sign of a - b
    assign lessVec = {{(numSlices-1){1'b0}}, less};

    assign zero = (result == '0);

endmodule

// File: logic/dataBusMaster.sv
`timescale 1ns/1ps

module dataBusMaster (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic                         memRead,
    input  logic                         memWrite,
    input  logic [coreCfgPkg::dataW-1:0] addr,
    input  logic [coreCfgPkg::dataW-1:0] storeData,
    output logic                         busy,
    output logic [coreCfgPkg::dataW-1:0] loadData,
    output logic                         busCyc,
    output logic                         busStb,
    output logic                         busWe,
    output logic [coreCfgPkg::dataW-1:0] busAdr,
    output logic [coreCfgPkg::dataW-1:0] busDatW,
    input  logic [coreCfgPkg::dataW-1:0] busDatR,
    input  logic                         busAck
);

    typedef enum logic {
        stIdle,
        stActive
    } busStateT;

    busStateT state;
    logic     request;                              // Current instr is lw or sw

    assign request = memRead | memWrite;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= stIdle;
            busWe <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (request) begin              // Open cycle on next edge
                        state <= stActive;
                        busWe <= memWrite;
                    end
                end
                stActive: begin
                    if (busAck) begin               // Done, PC moves on this edge
                        state <= stIdle;
                        busWe <= 1'b0;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Address and data latched once and held until ack
    always_ff @(posedge Clk) begin
        if (state == stIdle && request) begin
            busAdr <= addr;
            busDatW <= storeData;
        end
    end

    assign busCyc = (state == stActive);
    assign busStb = (state == stActive);            // Classic, one beat per cycle

    // Stall from request up to the ack cycle
    assign busy = (state == stIdle) ? request : ~busAck;
    assign loadData = busDatR;                      // Taken by regfile at ack edge

endmodule

// File: logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic                         Clk,
    input  logic                         rst,
    output logic                         busCyc,
    output logic                         busStb,
    output logic                         busWe,
    output logic [coreCfgPkg::dataW-1:0] busAdr,
    output logic [coreCfgPkg::dataW-1:0] busDatW,
    input  logic [coreCfgPkg::dataW-1:0] busDatR,
    input  logic                         busAck
);
    import isaPkg::*;
    import coreCfgPkg::*;

    logic [dataW-1:0]    pc;
    logic [dataW-1:0]    pcPlus4;
    logic [dataW-1:0]    nextPc;
    logic [dataW-1:0]    branchTarget;
    logic [dataW-1:0]    jumpTarget;
    logic [dataW-1:0]    instr;
    opcodeT              opcode;
    functT               funct;
    logic [regAddrW-1:0] rsAddr;
    logic [regAddrW-1:0] rtAddr;
    logic [regAddrW-1:0] rdAddr;
    logic [regAddrW-1:0] wrAddr;
    logic [dataW-1:0]    immExt;
    logic [dataW-1:0]    rsData;
    logic [dataW-1:0]    rtData;
    logic [dataW-1:0]    aluB;
    logic [dataW-1:0]    aluResult;
    logic [dataW-1:0]    loadData;
    logic [dataW-1:0]    wrData;
    logic                aluSrc;
    logic                regDst;
    logic                memRead;
    logic                memWrite;
    logic                memToReg;
    logic                regWrite;
    logic                beqEn;
    logic                bneEn;
    logic                jumpEn;
    aluOpT               aluOp;
    logic                aluZero;
    logic                busy;                      // Bus access still pending
    logic                branchTaken;
    logic                regWriteEn;

    instructionRom romInst (
        .pc    (pc),
        .instr (instr)
    );

    // Field split
    assign opcode = opcodeT'(instr[opcodeLsb +: $bits(opcodeT)]);
    assign funct = functT'(instr[0 +: $bits(functT)]);
    assign rsAddr = instr[rsLsb +: regAddrW];
    assign rtAddr = instr[rtLsb +: regAddrW];
    assign rdAddr = instr[rdLsb +: regAddrW];
    assign immExt = {{(dataW-immW){instr[immW-1]}}, instr[immW-1:0]}; // Sign extend

    controlDecoder decoderInst (
        .opcode   (opcode),
        .funct    (funct),
        .aluSrc   (aluSrc),
        .regDst   (regDst),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .regWrite (regWrite),
        .beqEn    (beqEn),
        .bneEn    (bneEn),
        .jumpEn   (jumpEn),
        .aluOp    (aluOp)
    );

    assign wrAddr = regDst ? rdAddr : rtAddr;       // R-type writes rd
    assign wrData = memToReg ? loadData : aluResult;
    assign regWriteEn = regWrite & ~busy;           // lw lands at the ack edge

    registerFile regFileInst (
        .Clk     (Clk),
        .rst     (rst),
        .rdAddrA (rsAddr),
        .rdAddrB (rtAddr),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (regWriteEn),
        .rdDataA (rsData),
        .rdDataB (rtData)
    );

    assign aluB = aluSrc ? immExt : rtData;

    alu aluInst (
        .a      (rsData),
        .b      (aluB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataBusMaster busMasterInst (
        .Clk       (Clk),
        .rst       (rst),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addr      (aluResult),                     // rs + imm
        .storeData (rtData),
        .busy      (busy),
        .loadData  (loadData),
        .busCyc    (busCyc),
        .busStb    (busStb),
        .busWe     (busWe),
        .busAdr    (busAdr),
        .busDatW   (busDatW),
        .busDatR   (busDatR),
        .busAck    (busAck)
    );

    // Next PC
    assign pcPlus4 = pc + dataW'(4);
    assign branchTarget = pcPlus4 + {immExt[dataW-3:0], 2'b00}; // Word offset
    assign jumpTarget = {pcPlus4[dataW-1:opcodeLsb+2], instr[opcodeLsb-1:0], 2'b00};
    assign branchTaken = (beqEn & aluZero) | (bneEn & ~aluZero);
    assign nextPc = jumpEn ? jumpTarget : (branchTaken ? branchTarget : pcPlus4);

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!busy) begin                   // Hold during bus wait
            pc <= nextPc;
        end
    end

endmodule

// File: tests/cpuCore_checker.sv
`timescale 1ns/1ps

module cpuCore_checker (
    input logic                         Clk,
    input logic                         rst,
    input logic                         busCyc,
    input logic                         busStb,
    input logic                         busWe,
    input logic [coreCfgPkg::dataW-1:0] busAdr,
    input logic [coreCfgPkg::dataW-1:0] busDatW,
    input logic                         busAck
);

    // Strobe only inside an open cycle
    stbInsideCyc: assert property (@(posedge Clk) disable iff (rst)
        busStb |-> busCyc)
        else $error("busStb high while busCyc is low");

    // Request frozen until the slave answers
    holdUntilAck: assert property (@(posedge Clk) disable iff (rst)
        (busStb && !busAck) |=> (busStb && $stable(busAdr) && $stable(busWe)
                                 && $stable(busDatW)))
        else $error("Bus request changed or vanished before busAck");

    // Classic cycle closes right after ack
    releaseAfterAck: assert property (@(posedge Clk) disable iff (rst)
        (busStb && busAck) |=> !busStb)
        else $error("busStb still high in the cycle after busAck");

endmodule

bind cpuCore cpuCore_checker checkerInst (
    .Clk     (Clk),
    .rst     (rst),
    .busCyc  (busCyc),
    .busStb  (busStb),
    .busWe   (busWe),
    .busAdr  (busAdr),
    .busDatW (busDatW),
    .busAck  (busAck)
);

// File: tests/cpuCore_tb.sv
`timescale 1ns/1ps

module tbClock (
    output logic Clk
);

    initial begin
        Clk = 1'b0;
        forever begin
            #2 Clk = ~Clk;                          // 4 ns period
        end
    end

endmodule

module cpuCore_tb;
    import isaPkg::*;
    import coreCfgPkg::*;

    localparam int romAw = $clog2(romDepth);
    localparam int numLoads = 8;                    // Pool of load return words
    localparam int maxSteps = 1000;                 // Model gives up past this
    localparam int accessTimeout = 100;             // Cycles between two accesses
    localparam int settleCycles = 20;               // Quiet time after last store
    localparam int resetCycles = 8;

    logic             Clk;
    logic             rst;
    logic             busCyc;
    logic             busStb;
    logic             busWe;
    logic [dataW-1:0] busAdr;
    logic [dataW-1:0] busDatW;
    logic [dataW-1:0] busDatR;
    logic             busAck;

    logic [31:0]      lcgState;
    logic [dataW-1:0] progMem [romDepth];           // Copy of program.hex
    logic [dataW-1:0] loadPool [numLoads];          // Words handed out by the slave

    logic [dataW-1:0] expAdr [$];                   // Access list from the model
    logic             expWe [$];
    logic [dataW-1:0] expDat [$];
    logic [dataW-1:0] obsAdr [$];                   // Accesses seen at ack
    logic             obsWe [$];
    logic [dataW-1:0] obsDat [$];

    int errors = 0;
    int checks = 0;

    tbClock clkGen (
        .Clk (Clk)
    );

    cpuCore cpuCore_i (
        .Clk     (Clk),
        .rst     (rst),
        .busCyc  (busCyc),
        .busStb  (busStb),
        .busWe   (busWe),
        .busAdr  (busAdr),
        .busDatW (busDatW),
        .busDatR (busDatR),
        .busAck  (busAck)
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;    // Numerical Recipes constants
    endfunction

    task automatic checkValue(input string sigName, input logic [dataW-1:0] got,
                              input logic [dataW-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, sigName, got, expected);
        end
    endtask

    // ISA model, walks program.hex and lists every bus access in order
    function automatic int runReference();
        logic [dataW-1:0]    regs [numRegs];
        logic [dataW-1:0]    pcRef;
        logic [dataW-1:0]    nextPcRef;
        logic [dataW-1:0]    instr;
        logic [dataW-1:0]    immExt;
        logic [dataW-1:0]    rsVal;
        logic [dataW-1:0]    rtVal;
        logic [regAddrW-1:0] rsIdx;
        logic [regAddrW-1:0] rtIdx;
        logic [regAddrW-1:0] rdIdx;
        int                  loadNum;
        int                  steps;
        logic                halted;
        for (int r = 0; r < numRegs; r++) begin
            regs[r] = '0;
        end
        pcRef = '0;
        loadNum = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < maxSteps) begin
            if (pcRef[dataW-1:2+romAw] == '0) begin
                instr = progMem[pcRef[2 +: romAw]];
            end else begin
                instr = '0;                         // Outside the ROM reads as nop
            end
            rsIdx = instr[rsLsb +: regAddrW];
            rtIdx = instr[rtLsb +: regAddrW];
            rdIdx = instr[rdLsb +: regAddrW];
            immExt = dataW'($signed(instr[immW-1:0]));
            rsVal = regs[rsIdx];
            rtVal = regs[rtIdx];
            nextPcRef = pcRef + 32'd4;
            case (instr[opcodeLsb +: 6])
                rType: begin
                    case (instr[5:0])
                        fAdd: regs[rdIdx] = rsVal + rtVal;
                        fSub: regs[rdIdx] = rsVal - rtVal;
                        fAnd: regs[rdIdx] = rsVal & rtVal;
                        fOr:  regs[rdIdx] = rsVal | rtVal;
                        fSlt: regs[rdIdx] = ($signed(rsVal) < $signed(rtVal)) ? dataW'(1) : '0;
                        default: ;                  // Unknown funct writes nothing
                    endcase
                end
                addi: regs[rtIdx] = rsVal + immExt;
                lw: begin
                    expAdr.push_back(rsVal + immExt);
                    expWe.push_back(1'b0);
                    expDat.push_back('0);           // Read data is not compared
                    regs[rtIdx] = (loadNum < numLoads) ? loadPool[loadNum] : '0;
                    loadNum++;
                end
                sw: begin
                    expAdr.push_back(rsVal + immExt);
                    expWe.push_back(1'b1);
                    expDat.push_back(rtVal);
                end
                beq: begin
                    if (rsVal == rtVal) begin
                        nextPcRef = pcRef + 32'd4 + (immExt << 2);
                    end
                end
                bne: begin
                    if (rsVal != rtVal) begin
                        nextPcRef = pcRef + 32'd4 + (immExt << 2);
                    end
                end
                j: begin
                    nextPcRef = {nextPcRef[dataW-1:opcodeLsb+2], instr[opcodeLsb-1:0], 2'b00};
                    halted = (nextPcRef == pcRef); // Jump to self ends the program
                end
                default: ;
            endcase
            regs[0] = '0;                           // r0 hardwired
            pcRef = nextPcRef;
            steps++;
        end
        return expAdr.size();
    endfunction

    // Bus slave, acks each strobe after 0 to 5 cycles
    initial begin
        logic [dataW-1:0] heldAdr;
        logic [dataW-1:0] heldDat;
        logic             heldWe;
        logic             pending;
        int               ackWait;
        int               loadIdx;
        heldAdr = '0;
        heldDat = '0;
        heldWe = 1'b0;
        pending = 1'b0;
        ackWait = 0;
        loadIdx = 0;
        forever begin
            @(posedge Clk);
            #1;
            if (busAck) begin
                busAck = 1'b0;                      // Single cycle ack
                busDatR = '0;
            end else if (busCyc && busStb) begin
                if (!pending) begin
                    pending = 1'b1;
                    heldAdr = busAdr;
                    heldWe = busWe;
                    heldDat = busDatW;
                    lcgState = lcgStep(lcgState);
                    ackWait = int'((lcgState >> 16) % 32'd6);
                end else begin
                    checkValue("busAdr", busAdr, heldAdr);      // Held while waiting
                    checkValue("busWe", dataW'(busWe), dataW'(heldWe));
                    checkValue("busDatW", busDatW, heldDat);
                end
                if (ackWait == 0) begin
                    if (!busWe) begin
                        busDatR = (loadIdx < numLoads) ? loadPool[loadIdx] : '0;
                        loadIdx++;
                    end
                    obsAdr.push_back(busAdr);
                    obsWe.push_back(busWe);
                    obsDat.push_back(busDatW);
                    busAck = 1'b1;
                    pending = 1'b0;
                end else begin
                    ackWait--;
                end
            end else if (pending) begin
                errors++;
                $display("Strobe dropped at %0t before the slave acknowledged it", $time);
                pending = 1'b0;
            end
        end
    end

    // Stimulus and comparison
    initial begin
        int               expCount;
        int               waitCycles;
        int               matched;
        logic             timedOut;
        logic [dataW-1:0] gotAdr;
        logic [dataW-1:0] gotDat;
        logic             gotWe;
        rst = 1'b1;
        busAck = 1'b0;
        busDatR = '0;
        matched = 0;
        timedOut = 1'b0;
        lcgState = 32'd77570;
        for (int w = 0; w < romDepth; w++) begin
            progMem[w] = '0;
        end
        $readmemh(programFile, progMem);
        for (int k = 0; k < numLoads; k++) begin
            lcgState = lcgStep(lcgState);
            loadPool[k] = lcgState;                 // Random load data
        end
        expCount = runReference();
        if (expCount == 0) begin
            errors++;
            $display("Reference model found no bus accesses in the program");
        end

        repeat (resetCycles) @(posedge Clk);
        #1;
        rst = 1'b0;
        checkValue("busCyc", dataW'(busCyc), '0);   // Bus idle out of reset
        checkValue("busStb", dataW'(busStb), '0);
        checkValue("busWe", dataW'(busWe), '0);

        for (int n = 0; n < expCount && !timedOut; n++) begin
            waitCycles = 0;
            while (obsAdr.size() == 0 && waitCycles < accessTimeout) begin
                @(posedge Clk);
                waitCycles++;
            end
            if (obsAdr.size() == 0) begin
                errors++;
                timedOut = 1'b1;
                $display("Timeout: bus access %0d did not arrive within %0d cycles",
                         n, accessTimeout);
            end else begin
                gotAdr = obsAdr.pop_front();
                gotWe = obsWe.pop_front();
                gotDat = obsDat.pop_front();
                checkValue("busAdr", gotAdr, expAdr[n]);
                checkValue("busWe", dataW'(gotWe), dataW'(expWe[n]));
                if (expWe[n]) begin
                    checkValue("busDatW", gotDat, expDat[n]);
                end
                matched++;
            end
        end

        if (!timedOut) begin
            waitCycles = 0;
            while (waitCycles < settleCycles) begin // Program now spins on j to self
                @(posedge Clk);
                waitCycles++;
            end
            checkValue("extraAccesses", dataW'(obsAdr.size()), '0);
        end

        $display("Accesses matched: %0d of %0d, checks: %0d, errors: %0d",
                 matched, expCount, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/isaPkg.sv
logic/coreCfgPkg.sv
logic/instructionRom.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/aluSlice.sv
logic/alu.sv
logic/dataBusMaster.sv
logic/cpuCore.sv
tests/cpuCore_checker.sv
tests/cpuCore_tb.sv

// File: Makefile
TOP := cpuCore_tb
SIM := obj_dir/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) > run.log 2>&1; status=$$?; cat run.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" run.log; then \
		echo "Simulation failed, see run.log"; exit 1; \
	fi

$(SIM): compile.f program.hex $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir run.log

// File: program.hex
// One instruction word per line in hex, line n sits at byte address 4*n
// Text after the word is the assembly for that word
20010064  // addi r1, r0, 100
2002FFF9  // addi r2, r0, -7
00221820  // add  r3, r1, r2
00412022  // sub  r4, r2, r1
00642824  // and  r5, r3, r4
00223025  // or   r6, r1, r2
0041382A  // slt  r7, r2, r1
0022402A  // slt  r8, r1, r2
AC030100  // sw   r3, 0x100(r0)
AC040104  // sw   r4, 0x104(r0)
AC050108  // sw   r5, 0x108(r0)
AC06010C  // sw   r6, 0x10C(r0)
AC070110  // sw   r7, 0x110(r0)
AC080114  // sw   r8, 0x114(r0)
8C2A0200  // lw   r10, 0x200(r1)
01425822  // sub  r11, r10, r2
AC0B0118  // sw   r11, 0x118(r0)
8C0C0020  // lw   r12, 0x20(r0)
AC0C011C  // sw   r12, 0x11C(r0)
20000037  // addi r0, r0, 55
10010005  // beq  r0, r1, +5
14220001  // bne  r1, r2, +1
AC010120  // sw   r1, 0x120(r0)
10210001  // beq  r1, r1, +1
AC020124  // sw   r2, 0x124(r0)
14630002  // bne  r3, r3, +2
0800001C  // j    28
AC020128  // sw   r2, 0x128(r0)
AC00012C  // sw   r0, 0x12C(r0)
0800001D  // j    29
